// ==== mpr121_pkg.sv ====
`default_nettype none

package mpr121_pkg;

	// ====================
	// bus constants
	localparam logic [6:0] MPR121_ADDR    = 7'h5A; // ADDR pin tied to ground
	localparam int         QUARTER_CYCLES = 125;   // 50 MHz over 4 x 100 kHz
	localparam int         QCNT_W         = $clog2(QUARTER_CYCLES);
	localparam logic [QCNT_W-1:0] QCNT_LAST = QCNT_W'(QUARTER_CYCLES - 1);
	localparam logic [5:0] COND_LAST_Q    = 6'd3;  // start or stop take 4 quarters
	localparam logic [5:0] BYTE_LAST_Q    = 6'd35; // 9 bits of 4 quarters

	// ====================
	// controller constants
	localparam int         SETTLE_CYCLES  = 500; // idle time after a write
	localparam int         SETTLE_W       = $clog2(SETTLE_CYCLES);
	localparam logic [SETTLE_W-1:0] SETTLE_LAST = SETTLE_W'(SETTLE_CYCLES - 1);
	localparam logic [7:0] SOFT_RESET_REG = 8'h80;
	localparam logic [7:0] SOFT_RESET_VAL = 8'h63;
	localparam logic [2:0] WR_LAST_STEP   = 3'd4; // stop slot of write list
	localparam logic [2:0] RD_LAST_STEP   = 3'd6; // stop slot of read list

	// engine operations
	typedef enum logic [1:0] {
		OP_START    = 2'd0, // start or repeated start
		OP_WRITE    = 2'd1, // byte out, ack sampled
		OP_READ_NAK = 2'd2, // byte in, master nak
		OP_STOP     = 2'd3
	} i2c_op_e;

	typedef struct packed {
		i2c_op_e    op;
		logic [7:0] data;
		logic       valid;
	} i2c_cmd_t;

	typedef struct packed {
		logic       done; // one clock pulse
		logic [7:0] data; // read byte
		logic       nak;  // ack bit seen high, write op only
	} i2c_rsp_t;

	typedef struct packed {
		logic scl_drive_low;
		logic sda_drive_low;
	} i2c_pad_t;

	// sequencer states
	typedef enum logic [2:0] {
		ST_RESET_LOAD   = 3'd0,
		ST_STANDBY      = 3'd1,
		ST_ISSUE        = 3'd2,
		ST_WAIT_RSP     = 3'd3,
		ST_SETTLE       = 3'd4,
		ST_WAIT_RELEASE = 3'd5
	} seq_state_e;

endpackage

`default_nettype wire

// ==== i2c_bit_engine.sv ====
`default_nettype none
`timescale 1ns/1ps

module i2c_bit_engine (
	input  wire                       i_CLK,
	input  wire                       i_RSTN,
	input  wire mpr121_pkg::i2c_cmd_t i_cmd,
	output logic                      o_cmd_ready,
	output mpr121_pkg::i2c_rsp_t      o_rsp,
	input  wire                       i_scl,
	input  wire                       i_sda,
	output mpr121_pkg::i2c_pad_t      o_pad
);

	// ====================
	// line inputs, two flop sync
	logic [1:0] r_scl_sync;
	logic [1:0] r_sda_sync;
	logic       w_scl_s;
	logic       w_sda_s;

	assign w_scl_s = r_scl_sync[1];
	assign w_sda_s = r_sda_sync[1];

	always_ff @(posedge i_CLK or negedge i_RSTN)
	begin
		if (!i_RSTN)
		begin
			r_scl_sync <= 2'b11; // idle bus reads high
			r_sda_sync <= 2'b11;
		end
		else
		begin
			r_scl_sync <= {r_scl_sync[0], i_scl};
			r_sda_sync <= {r_sda_sync[0], i_sda};
		end
	end

	// ====================
	// op state
	logic                          r_busy;
	mpr121_pkg::i2c_op_e           r_op;
	logic [7:0]                    r_shift;  // tx bits out of [7], rx bits into [0]
	logic [mpr121_pkg::QCNT_W-1:0] r_qcnt;   // clocks inside a quarter
	logic [5:0]                    r_qidx;   // {bit, quarter}
	logic                          r_nak;
	logic [1:0]                    w_quarter;
	logic [3:0]                    w_bit;
	logic [5:0]                    w_last_q;
	logic                          w_accept;
	logic                          w_q_end;
	logic                          w_op_end;
	logic                          w_sample; // end of first scl high quarter
	logic                          w_bit_end;
	logic                          w_scl_low_bit;
	mpr121_pkg::i2c_pad_t          w_pad_nxt;

	assign o_cmd_ready = !r_busy;
	assign w_accept    = i_cmd.valid && o_cmd_ready;
	assign w_quarter   = r_qidx[1:0];
	assign w_bit       = r_qidx[5:2];
	assign w_last_q    = (r_op == mpr121_pkg::OP_WRITE || r_op == mpr121_pkg::OP_READ_NAK) ?
		mpr121_pkg::BYTE_LAST_Q : mpr121_pkg::COND_LAST_Q;
	assign w_q_end     = r_busy && (r_qcnt == mpr121_pkg::QCNT_LAST);
	assign w_op_end    = w_q_end && (r_qidx == w_last_q);
	assign w_sample    = w_q_end && (w_quarter == 2'd1);
	assign w_bit_end   = w_q_end && (w_quarter == 2'd3);

	// scl low in q0 and q3, high in the middle two
	assign w_scl_low_bit = (w_quarter == 2'd0) || (w_quarter == 2'd3);

	// next pad drive from op and quarter
	always_comb
	begin
		case (r_op)
			mpr121_pkg::OP_START:
			begin
				w_pad_nxt.scl_drive_low = w_scl_low_bit;
				w_pad_nxt.sda_drive_low = w_quarter[1]; // sda falls in q2, scl high
			end
			mpr121_pkg::OP_STOP:
			begin
				w_pad_nxt.scl_drive_low = (w_quarter == 2'd0);
				w_pad_nxt.sda_drive_low = !w_quarter[1]; // sda rises in q2, scl high
			end
			mpr121_pkg::OP_WRITE:
			begin
				w_pad_nxt.scl_drive_low = w_scl_low_bit;
				w_pad_nxt.sda_drive_low = (w_bit < 4'd8) && !r_shift[7]; // 9th bit released
			end
			default:
			begin
				w_pad_nxt.scl_drive_low = w_scl_low_bit;
				w_pad_nxt.sda_drive_low = 1'b0; // target drives, 9th bit is nak
			end
		endcase
	end

	// control path
	always_ff @(posedge i_CLK or negedge i_RSTN)
	begin
		if (!i_RSTN)
		begin
			r_busy <= 1'b0;
			r_qcnt <= '0;
			r_qidx <= '0;
			r_nak  <= 1'b0;
			o_rsp  <= '0;
			o_pad  <= '0; // bus released
		end
		else
		begin
			o_rsp.done <= 1'b0;
			if (w_accept)
			begin
				r_busy <= 1'b1;
				r_qcnt <= '0;
				r_qidx <= '0;
				r_nak  <= 1'b0;
			end
			else if (r_busy)
			begin
				if (w_q_end)
				begin
					r_qcnt <= '0;
					r_qidx <= r_qidx + 6'd1;
				end
				else
					r_qcnt <= r_qcnt + 1'b1;
				// ack slot, a held scl also counts as a miss
				if (r_op == mpr121_pkg::OP_WRITE && w_sample && w_bit == 4'd8)
					r_nak <= w_sda_s || !w_scl_s;
				if (w_op_end)
				begin
					r_busy     <= 1'b0;
					o_rsp.done <= 1'b1;
					o_rsp.data <= r_shift;
					o_rsp.nak  <= r_nak;
				end
				o_pad <= w_pad_nxt; // pins lag the counters by a clock
			end
		end
	end

	// payload, loaded on accept
	always_ff @(posedge i_CLK)
	begin
		if (w_accept)
		begin
			r_op    <= i_cmd.op;
			r_shift <= i_cmd.data;
		end
		else if (r_op == mpr121_pkg::OP_READ_NAK && w_sample && w_bit < 4'd8)
			r_shift <= {r_shift[6:0], w_sda_s}; // msb arrives first
		else if (r_op == mpr121_pkg::OP_WRITE && w_bit_end && w_bit < 4'd8)
			r_shift <= {r_shift[6:0], 1'b0};    // next bit while scl low
	end

endmodule

`default_nettype wire

// ==== mpr121_sequencer.sv ====
`default_nettype none
`timescale 1ns/1ps

module mpr121_sequencer (
	input  wire                       i_CLK,
	input  wire                       i_RSTN,
	input  wire [7:0]                 i_reg_addr,
	input  wire [7:0]                 i_wr_data,
	input  wire                       i_write_en,
	input  wire                       i_read_en,
	output logic [7:0]                o_rd_data,
	output logic                      o_busy,
	output logic                      o_init_done,
	output logic                      o_fail,
	output mpr121_pkg::i2c_cmd_t      o_cmd,
	input  wire                       i_cmd_ready,
	input  wire mpr121_pkg::i2c_rsp_t i_rsp
);

	mpr121_pkg::seq_state_e          r_state;
	logic                            r_is_read;
	logic [2:0]                      r_step;       // slot in the op list
	logic                            r_nak_seen;
	logic [mpr121_pkg::SETTLE_W-1:0] r_settle_cnt;
	logic [7:0]                      r_reg;
	logic [7:0]                      r_data;
	logic [7:0]                      r_rd_byte;    // held until stop completes
	logic                            w_take;
	mpr121_pkg::i2c_op_e             w_cur_op;
	logic [7:0]                      w_cur_byte;

	// standby means init done and not busy
	assign w_take = (r_state == mpr121_pkg::ST_STANDBY) && (i_write_en || i_read_en);

	// ====================
	// op lists
	always_comb
	begin
		w_cur_op   = mpr121_pkg::OP_STOP;
		w_cur_byte = 8'h00;
		if (r_is_read)
		begin
			case (r_step)
				3'd0: w_cur_op = mpr121_pkg::OP_START;
				3'd1:
				begin
					w_cur_op   = mpr121_pkg::OP_WRITE;
					w_cur_byte = {mpr121_pkg::MPR121_ADDR, 1'b0}; // address, write
				end
				3'd2:
				begin
					w_cur_op   = mpr121_pkg::OP_WRITE;
					w_cur_byte = r_reg;
				end
				3'd3: w_cur_op = mpr121_pkg::OP_START; // repeated start
				3'd4:
				begin
					w_cur_op   = mpr121_pkg::OP_WRITE;
					w_cur_byte = {mpr121_pkg::MPR121_ADDR, 1'b1}; // address, read
				end
				3'd5: w_cur_op = mpr121_pkg::OP_READ_NAK;
				default: w_cur_op = mpr121_pkg::OP_STOP;
			endcase
		end
		else
		begin
			case (r_step)
				3'd0: w_cur_op = mpr121_pkg::OP_START;
				3'd1:
				begin
					w_cur_op   = mpr121_pkg::OP_WRITE;
					w_cur_byte = {mpr121_pkg::MPR121_ADDR, 1'b0};
				end
				3'd2:
				begin
					w_cur_op   = mpr121_pkg::OP_WRITE;
					w_cur_byte = r_reg;
				end
				3'd3:
				begin
					w_cur_op   = mpr121_pkg::OP_WRITE;
					w_cur_byte = r_data;
				end
				default: w_cur_op = mpr121_pkg::OP_STOP;
			endcase
		end
	end

	assign o_cmd.valid = (r_state == mpr121_pkg::ST_ISSUE);
	assign o_cmd.op    = w_cur_op;
	assign o_cmd.data  = w_cur_byte;

	// ====================
	// main fsm
	always_ff @(posedge i_CLK or negedge i_RSTN)
	begin
		if (!i_RSTN)
		begin
			r_state      <= mpr121_pkg::ST_RESET_LOAD;
			r_is_read    <= 1'b0;
			r_step       <= '0;
			r_nak_seen   <= 1'b0;
			r_settle_cnt <= '0;
			o_rd_data    <= '0;
			o_busy       <= 1'b0;
			o_init_done  <= 1'b0;
			o_fail       <= 1'b0;
		end
		else
		begin
			case (r_state)
				mpr121_pkg::ST_RESET_LOAD:
				begin
					r_is_read  <= 1'b0; // soft reset is a plain write
					r_step     <= '0;
					r_nak_seen <= 1'b0;
					r_state    <= mpr121_pkg::ST_ISSUE;
				end
				mpr121_pkg::ST_STANDBY:
				begin
					if (w_take)
					begin
						o_busy     <= 1'b1;
						o_fail     <= 1'b0;
						r_is_read  <= !i_write_en; // write wins
						r_step     <= '0;
						r_nak_seen <= 1'b0;
						r_state    <= mpr121_pkg::ST_ISSUE;
					end
				end
				mpr121_pkg::ST_ISSUE:
				begin
					if (i_cmd_ready)
						r_state <= mpr121_pkg::ST_WAIT_RSP; // accepted this edge
				end
				mpr121_pkg::ST_WAIT_RSP:
				begin
					if (i_rsp.done)
					begin
						if (w_cur_op == mpr121_pkg::OP_STOP)
						begin
							if (r_is_read)
							begin
								o_busy <= 1'b0;
								o_fail <= r_nak_seen;
								if (!r_nak_seen)
									o_rd_data <= r_rd_byte;
								r_state <= mpr121_pkg::ST_WAIT_RELEASE;
							end
							else
							begin
								r_settle_cnt <= '0;
								r_state      <= mpr121_pkg::ST_SETTLE;
							end
						end
						else if (w_cur_op == mpr121_pkg::OP_WRITE && i_rsp.nak)
						begin
							// missed ack, go straight to stop
							r_nak_seen <= 1'b1;
							r_step     <= r_is_read ? mpr121_pkg::RD_LAST_STEP :
								mpr121_pkg::WR_LAST_STEP;
							r_state    <= mpr121_pkg::ST_ISSUE;
						end
						else
						begin
							r_step  <= r_step + 3'd1;
							r_state <= mpr121_pkg::ST_ISSUE;
						end
					end
				end
				mpr121_pkg::ST_SETTLE:
				begin
					if (r_settle_cnt == mpr121_pkg::SETTLE_LAST)
					begin
						o_busy <= 1'b0;
						o_fail <= r_nak_seen;
						if (!o_init_done)
						begin
							o_init_done <= 1'b1; // raised even on a failed soft reset
							r_state     <= mpr121_pkg::ST_STANDBY;
						end
						else
							r_state <= mpr121_pkg::ST_WAIT_RELEASE;
					end
					else
						r_settle_cnt <= r_settle_cnt + 1'b1;
				end
				mpr121_pkg::ST_WAIT_RELEASE:
				begin
					// host must drop the enable it used
					if (!(r_is_read ? i_read_en : i_write_en))
						r_state <= mpr121_pkg::ST_STANDBY;
				end
				default: r_state <= mpr121_pkg::ST_RESET_LOAD;
			endcase
		end
	end

	// request bytes and read result
	always_ff @(posedge i_CLK)
	begin
		if (r_state == mpr121_pkg::ST_RESET_LOAD)
		begin
			r_reg  <= mpr121_pkg::SOFT_RESET_REG;
			r_data <= mpr121_pkg::SOFT_RESET_VAL;
		end
		else if (w_take)
		begin
			r_reg  <= i_reg_addr;
			r_data <= i_wr_data;
		end
		if (r_state == mpr121_pkg::ST_WAIT_RSP && i_rsp.done &&
			w_cur_op == mpr121_pkg::OP_READ_NAK)
			r_rd_byte <= i_rsp.data;
	end

endmodule

`default_nettype wire

// ==== mpr121_ctrl_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module mpr121_ctrl_top (
	input  wire        i_CLK,
	input  wire        i_RSTN,
	input  wire [7:0]  i_reg_addr,
	input  wire [7:0]  i_wr_data,
	input  wire        i_write_en,
	input  wire        i_read_en,
	output logic [7:0] o_rd_data,
	output logic       o_busy,
	output logic       o_init_done,
	output logic       o_fail,
	input  wire        i_scl,
	input  wire        i_sda,
	output logic       o_scl_drive_low,
	output logic       o_sda_drive_low
);

	mpr121_pkg::i2c_cmd_t w_cmd;       // sequencer to engine
	logic                 w_cmd_ready;
	mpr121_pkg::i2c_rsp_t w_rsp;       // engine to sequencer
	mpr121_pkg::i2c_pad_t w_pad;

	mpr121_sequencer u_mpr121_sequencer (
		.i_CLK       (i_CLK),
		.i_RSTN      (i_RSTN),
		.i_reg_addr  (i_reg_addr),
		.i_wr_data   (i_wr_data),
		.i_write_en  (i_write_en),
		.i_read_en   (i_read_en),
		.o_rd_data   (o_rd_data),
		.o_busy      (o_busy),
		.o_init_done (o_init_done),
		.o_fail      (o_fail),
		.o_cmd       (w_cmd),
		.i_cmd_ready (w_cmd_ready),
		.i_rsp       (w_rsp)
	);

	i2c_bit_engine u_i2c_bit_engine (
		.i_CLK       (i_CLK),
		.i_RSTN      (i_RSTN),
		.i_cmd       (w_cmd),
		.o_cmd_ready (w_cmd_ready),
		.o_rsp       (w_rsp),
		.i_scl       (i_scl),
		.i_sda       (i_sda),
		.o_pad       (w_pad)
	);

	// open drain pins
	assign o_scl_drive_low = w_pad.scl_drive_low;
	assign o_sda_drive_low = w_pad.sda_drive_low;

endmodule

`default_nettype wire

// ==== tb_i2c_target.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_i2c_target (
	input  wire         i_CLK,
	input  wire         i_RSTN,
	input  wire         i_scl,
	input  wire         i_sda,
	input  wire         i_nak_addr,      // refuse own address
	output logic        o_sda_drive_low,
	output logic [31:0] o_start_count    // start and repeated start
);

	typedef enum logic [2:0] {
		T_IDLE,
		T_ADDR,
		T_REG,
		T_DATA,
		T_READ
	} tgt_state_e;

	tgt_state_e        r_state;
	logic              r_scl_q;
	logic              r_sda_q;
	logic [3:0]        r_cnt;   // bit in byte, 8 is ack slot, 15 before first bit
	logic [7:0]        r_shift;
	logic [7:0]        r_ptr;   // register pointer, auto increment
	logic [255:0][7:0] r_mem;   // register file, zero at power-up
	logic              w_start;
	logic              w_stop;
	logic              w_rise;
	logic              w_fall;

	// bus events against the previous sample
	assign w_start = i_scl && r_scl_q && r_sda_q && !i_sda;
	assign w_stop  = i_scl && r_scl_q && !r_sda_q && i_sda;
	assign w_rise  = i_scl && !r_scl_q;
	assign w_fall  = !i_scl && r_scl_q;

	always @(posedge i_CLK or negedge i_RSTN)
	begin
		if (!i_RSTN)
		begin
			r_state         <= T_IDLE;
			r_scl_q         <= 1'b1;
			r_sda_q         <= 1'b1;
			r_cnt           <= 4'd0;
			r_shift         <= 8'h00;
			r_ptr           <= 8'h00;
			r_mem           <= '0;
			o_sda_drive_low <= 1'b0;
			o_start_count   <= 32'd0;
		end
		else
		begin
			r_scl_q <= i_scl;
			r_sda_q <= i_sda;
			if (w_start)
			begin
				r_state         <= T_ADDR;
				r_cnt           <= 4'd15; // scl fall of the start itself comes next
				o_sda_drive_low <= 1'b0;
				o_start_count   <= o_start_count + 32'd1;
			end
			else if (w_stop)
			begin
				r_state         <= T_IDLE;
				o_sda_drive_low <= 1'b0;
			end
			else if (r_state != T_IDLE)
			begin
				if (w_rise && r_cnt < 4'd8 && r_state != T_READ)
					r_shift <= {r_shift[6:0], i_sda}; // msb first
				if (w_fall)
				begin
					if (r_cnt == 4'd15)
						r_cnt <= 4'd0;
					else if (r_cnt < 4'd7)
					begin
						r_cnt <= r_cnt + 4'd1;
						if (r_state == T_READ)
						begin
							r_shift         <= {r_shift[6:0], 1'b0};
							o_sda_drive_low <= !r_shift[6];
						end
					end
					else if (r_cnt == 4'd7)
					begin
						// byte complete, ack slot follows
						r_cnt <= 4'd8;
						case (r_state)
							T_ADDR:
							begin
								if (r_shift[7:1] == mpr121_pkg::MPR121_ADDR && !i_nak_addr)
								begin
									o_sda_drive_low <= 1'b1;
									r_state         <= r_shift[0] ? T_READ : T_REG;
								end
								else
									r_state <= T_IDLE; // no ack, wait for stop
							end
							T_REG:
							begin
								o_sda_drive_low <= 1'b1;
								r_ptr           <= r_shift;
								r_state         <= T_DATA;
							end
							T_DATA:
							begin
								o_sda_drive_low <= 1'b1;
								r_mem[r_ptr]    <= r_shift;
								r_ptr           <= r_ptr + 8'd1;
							end
							default:
							begin
								o_sda_drive_low <= 1'b0; // master ack slot
								r_state         <= T_IDLE; // single byte reads
							end
						endcase
					end
					else
					begin
						// end of ack slot
						r_cnt <= 4'd0;
						if (r_state == T_READ)
						begin
							r_shift         <= r_mem[r_ptr];
							o_sda_drive_low <= !r_mem[r_ptr][7];
						end
						else
							o_sda_drive_low <= 1'b0;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== tb_mpr121.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_mpr121;

	localparam int     CLK_PERIOD  = 40;
	localparam int     N_RANDOM    = 10;
	localparam int     N_PAIRS     = 3;
	localparam int     N_TRANS     = 1 + N_RANDOM + 2 * N_PAIRS + 3; // init, random, pairs, nak
	localparam int     XFER_CYCLES = 7 * 40 * mpr121_pkg::QUARTER_CYCLES +
		mpr121_pkg::SETTLE_CYCLES;
	localparam int     WAIT_LIMIT  = 2 * XFER_CYCLES;
	localparam longint WATCHDOG_NS = longint'(N_TRANS) * longint'(XFER_CYCLES) * 2 * CLK_PERIOD;

	logic              i_CLK;
	logic              i_RSTN;
	logic [7:0]        i_reg_addr;
	logic [7:0]        i_wr_data;
	logic              i_write_en;
	logic              i_read_en;
	logic [7:0]        o_rd_data;
	logic              o_busy;
	logic              o_init_done;
	logic              o_fail;
	logic              o_scl_drive_low;
	logic              o_sda_drive_low;
	logic              tgt_sda_low;
	logic              scl_line;
	logic              sda_line;
	logic              nak_knob;      // target refuses its address
	logic [31:0]       start_count;
	logic [31:0]       lfsr;
	logic [255:0][7:0] model_mem;     // mirror of requested writes
	int                errors;
	int                transactions;

	// ====================
	// bus, wired-AND with pull-ups
	assign scl_line = !o_scl_drive_low; // only the master drives scl
	assign sda_line = !(o_sda_drive_low || tgt_sda_low);

	mpr121_ctrl_top u_mpr121_ctrl_top (
		.i_CLK           (i_CLK),
		.i_RSTN          (i_RSTN),
		.i_reg_addr      (i_reg_addr),
		.i_wr_data       (i_wr_data),
		.i_write_en      (i_write_en),
		.i_read_en       (i_read_en),
		.o_rd_data       (o_rd_data),
		.o_busy          (o_busy),
		.o_init_done     (o_init_done),
		.o_fail          (o_fail),
		.i_scl           (scl_line),
		.i_sda           (sda_line),
		.o_scl_drive_low (o_scl_drive_low),
		.o_sda_drive_low (o_sda_drive_low)
	);

	tb_i2c_target u_tb_i2c_target (
		.i_CLK           (i_CLK),
		.i_RSTN          (i_RSTN),
		.i_scl           (scl_line),
		.i_sda           (sda_line),
		.i_nak_addr      (nak_knob),
		.o_sda_drive_low (tgt_sda_low),
		.o_start_count   (start_count)
	);

	initial
	begin
		i_CLK = 1'b0;
		forever #(CLK_PERIOD / 2) i_CLK = ~i_CLK;
	end

	// galois lfsr, one step per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		int          k;
		v = 32'd0;
		for (k = 0; k < n; k++)
		begin
			lfsr = lfsr[0] ? ({1'b0, lfsr[31:1]} ^ 32'hD0000001) : {1'b0, lfsr[31:1]};
			v    = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	task automatic log_mismatch(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		errors++;
		$display("ERROR t=%0t %s expected %0h got %0h", $time, name, exp, act);
	endtask

	// falling edges only, outputs settled there
	task automatic wait_busy(input logic level, input string what);
		int n;
		n = 0;
		while (o_busy !== level && n < WAIT_LIMIT)
		begin
			@(negedge i_CLK);
			n++;
		end
		if (o_busy !== level)
		begin
			errors++;
			$display("timeout at %0t, busy never went %0d during %s", $time, level, what);
		end
	endtask

	// ====================
	// one host request, checked against the model
	task automatic run_request(input logic is_wr, input logic [7:0] addr,
		input logic [7:0] data, input int hold);
		logic [31:0] starts_exp;
		logic [7:0]  rd_before;
		logic [7:0]  exp_rd;
		@(posedge i_CLK);
		starts_exp = start_count + ((is_wr || nak_knob) ? 32'd1 : 32'd2); // nak stops early
		rd_before  = o_rd_data;
		i_reg_addr <= addr;
		i_wr_data  <= data;
		if (is_wr)
			i_write_en <= 1'b1;
		else
			i_read_en <= 1'b1;
		wait_busy(1'b1, "request");
		if (o_fail !== 1'b0)
			log_mismatch("o_fail", 32'd0, 32'(o_fail)); // cleared on take
		wait_busy(1'b0, "transfer");
		if (is_wr && !nak_knob)
			model_mem[addr] = data;
		if (o_fail !== nak_knob)
			log_mismatch("o_fail", 32'(nak_knob), 32'(o_fail));
		if (start_count !== starts_exp)
			log_mismatch("start_count", starts_exp, start_count);
		// stop leaves the bus released
		if (o_scl_drive_low !== 1'b0)
			log_mismatch("o_scl_drive_low", 32'd0, 32'(o_scl_drive_low));
		if (o_sda_drive_low !== 1'b0)
			log_mismatch("o_sda_drive_low", 32'd0, 32'(o_sda_drive_low));
		if (is_wr)
		begin
			if (u_tb_i2c_target.r_mem[addr] !== model_mem[addr])
				log_mismatch("target r_mem", 32'(model_mem[addr]),
					32'(u_tb_i2c_target.r_mem[addr]));
		end
		else
		begin
			exp_rd = nak_knob ? rd_before : model_mem[addr];
			if (o_rd_data !== exp_rd)
				log_mismatch("o_rd_data", 32'(exp_rd), 32'(o_rd_data));
		end
		// enable still high, nothing new may start
		repeat (hold)
		begin
			@(negedge i_CLK);
			if (o_busy !== 1'b0)
				log_mismatch("o_busy", 32'd0, 32'(o_busy));
			if (start_count !== starts_exp)
				log_mismatch("start_count", starts_exp, start_count);
		end
		@(posedge i_CLK);
		i_write_en <= 1'b0;
		i_read_en  <= 1'b0;
		transactions++;
	endtask

	// ====================
	// test sequence
	initial
	begin
		logic [31:0] rnd;
		logic [7:0]  a;
		logic [7:0]  d;
		logic        wr;
		int          i;
		int          n;
		lfsr         = 32'h8c0311ac;
		errors       = 0;
		transactions = 0;
		model_mem    = '0;  // target power-up contents
		i_RSTN       = 1'b0;
		i_reg_addr   = 8'h00;
		i_wr_data    = 8'h00;
		i_write_en   = 1'b0;
		i_read_en    = 1'b0;
		nak_knob     = 1'b0;
		a            = 8'h00;
		d            = 8'h00;
		repeat (4) @(posedge i_CLK);

		// all outputs quiet under reset
		if (o_rd_data !== 8'h00)
			log_mismatch("o_rd_data", 32'd0, 32'(o_rd_data));
		if (o_busy !== 1'b0)
			log_mismatch("o_busy", 32'd0, 32'(o_busy));
		if (o_init_done !== 1'b0)
			log_mismatch("o_init_done", 32'd0, 32'(o_init_done));
		if (o_fail !== 1'b0)
			log_mismatch("o_fail", 32'd0, 32'(o_fail));
		if (o_scl_drive_low !== 1'b0)
			log_mismatch("o_scl_drive_low", 32'd0, 32'(o_scl_drive_low));
		if (o_sda_drive_low !== 1'b0)
			log_mismatch("o_sda_drive_low", 32'd0, 32'(o_sda_drive_low));
		i_RSTN <= 1'b1;

		// soft reset write after reset
		n = 0;
		while (o_init_done !== 1'b1 && n < WAIT_LIMIT)
		begin
			@(negedge i_CLK);
			n++;
		end
		if (o_init_done !== 1'b1)
		begin
			errors++;
			$display("timeout at %0t, init never completed", $time);
		end
		if (o_fail !== 1'b0)
			log_mismatch("o_fail", 32'd0, 32'(o_fail));
		if (u_tb_i2c_target.r_mem[mpr121_pkg::SOFT_RESET_REG] !== mpr121_pkg::SOFT_RESET_VAL)
			log_mismatch("target r_mem[80]", 32'(mpr121_pkg::SOFT_RESET_VAL),
				32'(u_tb_i2c_target.r_mem[mpr121_pkg::SOFT_RESET_REG]));

		// random reads and writes
		for (i = 0; i < N_RANDOM; i++)
		begin
			rnd = take_bits(1);
			wr  = rnd[0];
			rnd = take_bits(7);
			a   = {1'b0, rnd[6:0]};
			rnd = take_bits(8);
			d   = rnd[7:0];
			rnd = take_bits(3);
			run_request(wr, a, d, 2 + int'(rnd[2:0]));
		end

		// write then read back the same register
		for (i = 0; i < N_PAIRS; i++)
		begin
			rnd = take_bits(7);
			a   = {1'b0, rnd[6:0]};
			rnd = take_bits(8);
			d   = rnd[7:0];
			run_request(1'b1, a, d, 2);
			run_request(1'b0, a, 8'h00, 2);
		end

		// address refused, then recovery
		@(posedge i_CLK);
		nak_knob <= 1'b1;
		run_request(1'b0, a, 8'h00, 2); // rd_data must hold
		run_request(1'b1, a, ~d, 2);    // register untouched
		@(posedge i_CLK);
		nak_knob <= 1'b0;
		run_request(1'b0, a, 8'h00, 3);

		$display("requests %0d, errors %0d", transactions, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	// watchdog, sized from the transfer count
	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog expired at %0t before the test sequence finished", $time);
		$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
mpr121_pkg.sv
i2c_bit_engine.sv
mpr121_sequencer.sv
mpr121_ctrl_top.sv
tb_i2c_target.sv
tb_mpr121.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the MPR121 controller testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"
verilator --binary --timing -j 0 --top-module tb_mpr121 -f list.f -o sim_tb_mpr121
./obj_dir/sim_tb_mpr121 | tee sim.log
if grep -q '\*\* FAIL \*\*' sim.log; then
	echo "simulation failed, see sim.log"
	exit 1
fi
echo "simulation passed"
